//--- build.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/req_queue.sv
rtl/cache_ctrl.sv
rtl/line_mem.sv
rtl/cache_top.sv
verif/cache_tb.sv

//--- rtl/cache_ctrl.sv
// Direct-mapped cache controller, write-through with no write allocate.
// Serves one queued request at a time and fetches whole lines on read misses.
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        empty,
  input  cache_req_t  head,
  output logic        pop,
  output logic        done,
  output cache_resp_t resp,
  output logic        mem_strobe,
  output mem_req_t    mem_req,
  input  logic        mem_valid,
  input  line_t       mem_line
);

  localparam int NUM_LINES = 1 << `CACHE_IDX_W;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  cache_req_t               cur;
  logic [`CACHE_TAG_W-1:0]  cur_tag;
  logic [`CACHE_IDX_W-1:0]  cur_idx;
  logic [`CACHE_OFF_W-1:0]  cur_off;
  logic                     hit;
  logic                     hit_q;
  logic                     fill_done;

  logic [NUM_LINES-1:0]     valid_bits;
  logic [`CACHE_TAG_W-1:0]  tags  [NUM_LINES];
  line_t                    lines [NUM_LINES];

  assign cur_tag = cur.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign cur_idx = cur.addr[`CACHE_OFF_W +: `CACHE_IDX_W];
  assign cur_off = cur.addr[`CACHE_OFF_W-1:0];

  assign hit       = valid_bits[cur_idx] && (tags[cur_idx] == cur_tag);
  assign fill_done = (state == FILL_WAIT) && mem_valid && (cur.op == OP_READ);

  assign pop        = (state == IDLE) && !empty;
  assign done       = (state == RESPOND);
  assign mem_strobe = (state == FILL_REQ) || (state == WRITE_MEM);

  always_comb begin
    mem_req.op    = cur.op;
    mem_req.addr  = cur.addr;
    mem_req.wdata = cur.wdata;
    if (cur.op == OP_READ) begin
      mem_req.addr[`CACHE_OFF_W-1:0] = '0; // fills always fetch from the line start.
      mem_req.wdata                  = '0;
    end
  end

  // FILL_WAIT is the memory wait for both fills and forwarded writes.
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (!empty) begin
          state_nxt = LOOKUP;
        end
      end
      LOOKUP: begin
        if (cur.op == OP_WRITE) begin
          state_nxt = WRITE_MEM;
        end else if (hit) begin
          state_nxt = RESPOND;
        end else begin
          state_nxt = FILL_REQ;
        end
      end
      WRITE_MEM: state_nxt = FILL_WAIT;
      FILL_REQ:  state_nxt = FILL_WAIT;
      FILL_WAIT: begin
        if (mem_valid) begin
          state_nxt = RESPOND;
        end
      end
      RESPOND:   state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      valid_bits <= '0;
    end else begin
      state <= state_nxt;
      if (fill_done) begin
        valid_bits[cur_idx] <= 1'b1;
      end
    end
  end

  // resp only changes on the edge into RESPOND, so it holds between done pulses.
  always_ff @(posedge clk) begin
    if (pop) begin
      cur <= head;
    end

    if (state == LOOKUP) begin
      hit_q <= hit;
      if (cur.op == OP_READ && hit) begin
        resp.op    <= OP_READ;
        resp.hit   <= 1'b1;
        resp.rdata <= lines[cur_idx][cur_off];
      end
      if (cur.op == OP_WRITE && hit) begin
        lines[cur_idx][cur_off] <= cur.wdata; // memory gets the same word next cycle.
      end
    end

    if (state == FILL_WAIT && mem_valid) begin
      if (cur.op == OP_READ) begin
        lines[cur_idx] <= mem_line;
        tags[cur_idx]  <= cur_tag;
        resp.op        <= OP_READ;
        resp.hit       <= 1'b0;
        resp.rdata     <= mem_line[cur_off];
      end else begin
        resp.op    <= OP_WRITE;
        resp.hit   <= hit_q;
        resp.rdata <= '0;
      end
    end
  end

endmodule

//--- rtl/cache_params.svh
// Size and timing constants shared by the cache subsystem.
// Addresses count 32-bit words, not bytes.
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word address width and data word width.
`define CACHE_ADDR_W 16
`define CACHE_WORD_W 32

// a line holds four words, and the cache has sixteen lines.
`define CACHE_OFF_W 2
`define CACHE_IDX_W 4

// tag is whatever remains of the address above index and offset.
`define CACHE_TAG_W 10

`define CACHE_QUEUE_DEPTH 4

// cycles from a memory request strobe to its valid pulse, at least two.
`define CACHE_MEM_LAT 4

`endif

//--- rtl/cache_pkg.sv
// Types shared by the request queue, the cache controller and the backing memory.
`include "cache_params.svh"

package cache_pkg;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } req_op_e;

  typedef struct packed {
    req_op_e                 op;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_WORD_W-1:0] wdata;
  } cache_req_t;

  typedef struct packed {
    req_op_e                 op;
    logic                    hit;
    logic [`CACHE_WORD_W-1:0] rdata; // zero for writes.
  } cache_resp_t;

  typedef struct packed {
    req_op_e                 op;
    logic [`CACHE_ADDR_W-1:0] addr; // line-aligned for reads.
    logic [`CACHE_WORD_W-1:0] wdata;
  } mem_req_t;

  typedef logic [(1 << `CACHE_OFF_W)-1:0][`CACHE_WORD_W-1:0] line_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITE_MEM,
    FILL_REQ,
    FILL_WAIT,
    RESPOND
  } ctrl_state_e;

endpackage

//--- rtl/cache_top.sv
// Cache subsystem top level.
// The request queue feeds the cache controller, which talks to the backing memory.
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  cache_req_t  req,
  output logic        full,
  output logic        done,
  output cache_resp_t resp
);

  logic       q_empty;
  logic       q_pop;
  cache_req_t q_head;
  logic       mem_strobe;
  mem_req_t   mem_req;
  logic       mem_valid;
  line_t      mem_line;

  req_queue u_queue (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .req   (req),
    .full  (full),
    .pop   (q_pop),
    .head  (q_head),
    .empty (q_empty)
  );

  cache_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .empty      (q_empty),
    .head       (q_head),
    .pop        (q_pop),
    .done       (done),
    .resp       (resp),
    .mem_strobe (mem_strobe),
    .mem_req    (mem_req),
    .mem_valid  (mem_valid),
    .mem_line   (mem_line)
  );

  line_mem u_mem (
    .clk    (clk),
    .rst    (rst),
    .strobe (mem_strobe),
    .req    (mem_req),
    .valid  (mem_valid),
    .line   (mem_line)
  );

endmodule

//--- rtl/line_mem.sv
// Backing memory behind the cache.
// Reads return a whole aligned line, writes store one word, both after a fixed latency.
`timescale 1ns/1ps
`include "cache_params.svh"

module line_mem
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     strobe,
  input  mem_req_t req,
  output logic     valid,
  output line_t    line
);

  localparam int MEM_WORDS  = 1 << `CACHE_ADDR_W;
  localparam int LINE_WORDS = 1 << `CACHE_OFF_W;
  localparam int LAT        = `CACHE_MEM_LAT;
  localparam int CNT_W      = $clog2(LAT + 1);

  logic [`CACHE_WORD_W-1:0] mem [MEM_WORDS];
  mem_req_t                 pend;
  logic [CNT_W-1:0]         cnt;
  logic                     fire;
  logic [`CACHE_ADDR_W-1:0] line_base;

  // the access completes on the edge where the count runs out.
  assign fire      = !strobe && (cnt == CNT_W'(1));
  assign line_base = {pend.addr[`CACHE_ADDR_W-1:`CACHE_OFF_W], {`CACHE_OFF_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      valid <= 1'b0;
    end else begin
      valid <= fire;
      if (strobe) begin
        cnt <= CNT_W'(LAT - 1);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) begin
      pend <= req;
    end
    if (fire) begin
      if (pend.op == OP_WRITE) begin
        mem[pend.addr] <= pend.wdata; // line keeps its old value on writes.
      end else begin
        for (int w = 0; w < LINE_WORDS; w++) begin
          line[w] <= mem[line_base + `CACHE_ADDR_W'(w)];
        end
      end
    end
  end

endmodule

//--- rtl/req_queue.sv
// Request queue between the CPU port and the cache controller.
// Circular FIFO with the oldest entry shown on head.
`timescale 1ns/1ps
`include "cache_params.svh"

module req_queue
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  cache_req_t req,
  output logic       full,
  input  logic       pop,
  output cache_req_t head,
  output logic       empty
);

  localparam int DEPTH = `CACHE_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  cache_req_t       entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wraps for any depth.
    return nxt;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full; // a push into a full queue is dropped.
  assign do_pop  = pop && !empty;
  assign head    = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither leave the level unchanged.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      entries[wr_ptr] <= req;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cache_tb -o cache_sim

rm -f sim.log
status=0
./obj_dir/cache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a pass result"
  exit 1
fi
echo "simulation passed"

//--- verif/cache_tb.sv
// Testbench for the cache subsystem.
// Acts as the CPU, keeps a reference model of memory and cache state, checks every response.
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int TIMEOUT     = 200;
  localparam int NUM_SLOTS   = 36;
  localparam int NUM_LINES   = 1 << `CACHE_IDX_W;
  localparam int HIT_LAT     = 2;
  localparam int MISS_LAT    = 3 + `CACHE_MEM_LAT;
  localparam int RANDOM_REQS = 150;

  logic        clk = 1'b0;
  logic        rst;
  logic        push;
  cache_req_t  req;
  logic        full;
  logic        done;
  cache_resp_t resp;

  logic [`CACHE_WORD_W-1:0] ref_val      [NUM_SLOTS];
  logic                     slot_written [NUM_SLOTS];
  int                       written_q    [$];
  logic                     line_valid   [NUM_LINES];
  logic [`CACHE_TAG_W-1:0]  line_tag     [NUM_LINES];
  cache_resp_t              exp_q        [$];
  int                       sent_count;
  int                       done_count;
  logic                     saw_full;

  cache_top uut (
    .clk  (clk),
    .rst  (rst),
    .push (push),
    .req  (req),
    .full (full),
    .done (done),
    .resp (resp)
  );

  always #50 clk = ~clk;

  task automatic fail_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("[FAIL] time %0t: %s expected %h, got %h", $time, name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic fail_event(input string what);
    $display("[FAIL] time %0t: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // three indices with three tags each, so lines conflict and get evicted.
  function automatic logic [`CACHE_ADDR_W-1:0] slot_addr(input int slot);
    logic [`CACHE_IDX_W-1:0] idx;
    logic [`CACHE_TAG_W-1:0] tag;
    case (slot / 12)
      0:       idx = 4'd3;
      1:       idx = 4'd9;
      default: idx = 4'd12;
    endcase
    case ((slot / 4) % 3)
      0:       tag = 10'h005;
      1:       tag = 10'h1a3;
      default: tag = 10'h3f0;
    endcase
    return {tag, idx, 2'(slot % 4)};
  endfunction

  task automatic predict_response(input req_op_e op, input int slot,
                                  input logic [31:0] wdata, output logic hit);
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_IDX_W-1:0]  idx;
    logic [`CACHE_TAG_W-1:0]  tag;
    cache_resp_t              e;
    addr  = slot_addr(slot);
    idx   = addr[`CACHE_OFF_W +: `CACHE_IDX_W];
    tag   = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    hit   = line_valid[idx] && (line_tag[idx] == tag);
    e.op  = op;
    e.hit = hit;
    if (op == OP_READ) begin
      e.rdata = ref_val[slot];
      if (!hit) begin
        line_valid[idx] = 1'b1; // only a read miss allocates a line.
        line_tag[idx]   = tag;
      end
    end else begin
      e.rdata       = '0;
      ref_val[slot] = wdata;
      if (!slot_written[slot]) begin
        slot_written[slot] = 1'b1;
        written_q.push_back(slot);
      end
    end
    exp_q.push_back(e);
  endtask

  // called on a falling edge, returns on the next one with push low again.
  task automatic send_request(input req_op_e op, input int slot,
                              input logic [31:0] wdata, output logic hit);
    int waited;
    waited = 0;
    while (full) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        fail_event("full stayed high and the queue never drained");
      end
    end
    push      = 1'b1;
    req.op    = op;
    req.addr  = slot_addr(slot);
    req.wdata = (op == OP_WRITE) ? wdata : '0;
    predict_response(op, slot, wdata, hit);
    sent_count++;
    @(negedge clk);
    push = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        fail_event("responses still outstanding after the timeout");
      end
    end
    @(negedge clk); // the controller leaves RESPOND on this edge.
  endtask

  task automatic timed_request(input req_op_e op, input int slot, input logic [31:0] wdata);
    logic hit;
    int   cycles;
    int   expected;
    wait_idle();
    send_request(op, slot, wdata, hit);
    assert (uut.q_pop === 1'b1) else fail_value("pop", 32'd1, 32'(uut.q_pop));
    expected = (op == OP_READ && hit) ? HIT_LAT : MISS_LAT;
    cycles   = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_event("no done pulse for a request sent to an idle cache");
      end
    end
    assert (cycles == expected) else fail_value("done latency", 32'(expected), 32'(cycles));
  endtask

  always @(negedge clk) begin : check_resp
    cache_resp_t e;
    if (!rst) begin
      if (full) begin
        saw_full = 1'b1;
      end
      if (done) begin
        assert (exp_q.size() > 0) else fail_event("done pulsed with no request outstanding");
        e = exp_q.pop_front();
        done_count++;
        assert (resp.op === e.op) else fail_value("resp.op", 32'(e.op), 32'(resp.op));
        assert (resp.hit === e.hit) else fail_value("resp.hit", 32'(e.hit), 32'(resp.hit));
        assert (resp.rdata === e.rdata) else fail_value("resp.rdata", e.rdata, resp.rdata);
      end
    end
  end

  initial begin
    logic        hit;
    logic [31:0] value;
    int          slot;
    req_op_e     op;
    void'($urandom(32'h77f93e03));
    rst        = 1'b1;
    push       = 1'b0;
    req        = '0;
    sent_count = 0;
    done_count = 0;
    saw_full   = 1'b0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      ref_val[i]      = '0;
      slot_written[i] = 1'b0;
    end
    for (int i = 0; i < NUM_LINES; i++) begin
      line_valid[i] = 1'b0;
      line_tag[i]   = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (done === 1'b0 && full === 1'b0) else fail_event("done or full not low after reset");

    // write miss leaves the line uncached, the read after it allocates.
    timed_request(OP_WRITE, 0, 32'h1111_0000);
    timed_request(OP_READ, 0, '0);
    timed_request(OP_READ, 0, '0);
    timed_request(OP_WRITE, 0, 32'h2222_0000);
    timed_request(OP_READ, 0, '0);
    timed_request(OP_WRITE, 4, 32'h3333_0004); // same index, other tag.
    timed_request(OP_READ, 4, '0);
    timed_request(OP_READ, 0, '0);

    // Back-to-back writes keep the controller busy until the queue fills.
    wait_idle();
    saw_full = 1'b0;
    for (int i = 0; i < 8; i++) begin
      value = $urandom;
      send_request(OP_WRITE, 12 + i, value, hit);
    end
    assert (saw_full) else fail_event("full never rose during the burst of pushes");

    for (int n = 0; n < RANDOM_REQS; n++) begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      if ($urandom_range(9, 0) < 6) begin
        slot = written_q[$urandom_range(written_q.size() - 1, 0)];
        op   = OP_READ;
      end else begin
        slot = $urandom_range(NUM_SLOTS - 1, 0);
        op   = OP_WRITE;
      end
      value = $urandom;
      send_request(op, slot, value, hit);
    end

    wait_idle();
    repeat (2 * MISS_LAT) @(negedge clk); // a stray done here finds no request outstanding.
    if (done_count == sent_count) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_value("done count", 32'(sent_count), 32'(done_count));
    end
  end

endmodule
